// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the execution unit testbench with Verilator.
set -u

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --top-module tb_exu \
  -f vlog.f --Mdir obj_dir -o sim_exu
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/sim_exu > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "Test completed successfully" "$LOG"; then
  exit 0
fi
echo "pass line not found in $LOG"
exit 1

// File: test/clk_rst_gen.sv
`timescale 1ns/1ns
`default_nettype none

module clk_rst_gen #(
  parameter int RESET_CYCLES = 4
) (
  output logic clk_o,
  output logic rst_o
);

  initial begin
    clk_o = 1'b0;
    forever #5 clk_o = ~clk_o; // 10 ns period.
  end

  initial begin
    rst_o = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk_o);
    @(negedge clk_o);
    rst_o = 1'b0; // released away from the sampling edge.
  end

endmodule

`default_nettype wire

// File: test/exu_properties.sv
`timescale 1ns/1ns
`default_nettype none

module exu_properties #(
  parameter int XLEN = 64
) (
  input logic            clk,
  input logic            rst,
  input logic            retire_valid_i,
  input logic            illegal_i,
  input logic [XLEN-1:0] x0_val_i
);

  // a taken instruction either retires or is flagged, never both.
  assert property (@(posedge clk) disable iff (rst) !(retire_valid_i && illegal_i))
    else $error("retire_valid_o and illegal_o high in the same cycle");

  assert property (@(posedge clk) rst |=> (!retire_valid_i && !illegal_i))
    else $error("retire or illegal flag high right after reset");

  assert property (@(posedge clk) disable iff (rst) x0_val_i == '0)
    else $error("register x0 holds a nonzero value");

endmodule

`default_nettype wire

// File: test/tb_exu.sv
`timescale 1ns/1ns
`default_nettype none

module tb_exu;

  import rv_isa_pkg::*;
  import exu_pkg::*;

  localparam int XLEN           = 64;
  localparam int NUM_INSTR      = 400;
  localparam int RESET_CYCLES   = 4;
  localparam int TIMEOUT_CYCLES = NUM_INSTR + RESET_CYCLES + 100;

  logic            clk;
  logic            rst;
  logic            instr_valid;
  instr_t          instr;
  logic [XLEN-1:0] pc;
  logic            retire_valid;
  logic [XLEN-1:0] retire_pc;
  reg_idx_t        retire_rd;
  logic [XLEN-1:0] retire_data;
  logic            illegal;

  integer          seed;
  int              cycle_count;
  logic [XLEN-1:0] shadow [nregs]; // expected register contents.
  logic [XLEN-1:0] pc_next;
  logic            exp_retire;
  logic            exp_illegal;
  logic [XLEN-1:0] exp_pc;
  logic [XLEN-1:0] exp_data;
  reg_idx_t        exp_rd;

  clk_rst_gen #(
    .RESET_CYCLES (RESET_CYCLES)
  ) clk_rst_i (
    .clk_o (clk),
    .rst_o (rst)
  );

  exu_top #(
    .XLEN (XLEN)
  ) dut_i (
    .clk            (clk),
    .rst            (rst),
    .instr_valid_i  (instr_valid),
    .instr_i        (instr),
    .pc_i           (pc),
    .retire_valid_o (retire_valid),
    .retire_pc_o    (retire_pc),
    .retire_rd_o    (retire_rd),
    .retire_data_o  (retire_data),
    .illegal_o      (illegal)
  );

  bind exu_top exu_properties #(.XLEN(XLEN)) props_i (
    .clk            (clk),
    .rst            (rst),
    .retire_valid_i (retire_valid_o),
    .illegal_i      (illegal_o),
    .x0_val_i       (regfile_i.regs[0])
  );

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("Test failed");
    $fatal(1, "stopping at the first error");
  endtask

  task automatic check_data(input string name, input logic [XLEN-1:0] got,
                            input logic [XLEN-1:0] exp);
    if (got !== exp) begin
      fail_run($sformatf("MISMATCH time=%0t signal=%s got=%h expected=%h",
                         $time, name, got, exp));
    end
  endtask

  task automatic check_rd(input string name, input reg_idx_t got, input reg_idx_t exp);
    if (got !== exp) begin
      fail_run($sformatf("MISMATCH time=%0t signal=%s got=%0d expected=%0d",
                         $time, name, got, exp));
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      fail_run($sformatf("MISMATCH time=%0t signal=%s got=%b expected=%b",
                         $time, name, got, exp));
    end
  endtask

  function automatic logic [31:0] rand_word();
    return $random(seed);
  endfunction

  // half of the indices fall in x0..x7, so dependences and x0 show up often.
  function automatic reg_idx_t rand_reg();
    logic [31:0] r;
    r = rand_word();
    return r[5] ? {2'b00, r[2:0]} : r[4:0];
  endfunction

  function automatic logic [XLEN-1:0] model_result(input logic [2:0] f3, input logic alt,
                                                   input logic [XLEN-1:0] a,
                                                   input logic [XLEN-1:0] b);
    logic [5:0]      sh;
    logic [XLEN-1:0] res;
    sh = b[5:0];
    case (f3)
      f3_add:  res = alt ? a - b : a + b;
      f3_sll:  res = a << sh;
      f3_slt:  res = ($signed(a) < $signed(b)) ? 64'd1 : 64'd0;
      f3_sltu: res = (a < b) ? 64'd1 : 64'd0;
      f3_xor:  res = a ^ b;
      f3_srl:  res = alt ? $unsigned($signed(a) >>> sh) : a >> sh;
      f3_or:   res = a | b;
      f3_and:  res = a & b;
      default: res = '0;
    endcase
    return res;
  endfunction

  // builds one instruction, drives it and records what must retire.
  task automatic issue_instr(input int slot);
    logic [31:0]     r;
    int unsigned     pick;
    reg_idx_t        rd;
    reg_idx_t        rs1;
    reg_idx_t        rs2;
    logic [2:0]      f3;
    logic [11:0]     imm12;
    logic [31:0]     word;
    logic            legal;
    logic            alt;
    logic            valid;
    logic [XLEN-1:0] a;
    logic [XLEN-1:0] b;
    logic [XLEN-1:0] res;

    pick  = rand_word() % 32'd100;
    rd    = rand_reg();
    rs1   = rand_reg();
    rs2   = rand_reg();
    r     = rand_word();
    f3    = r[2:0];
    imm12 = r[15:4];
    valid = (rand_word() % 32'd10) != 32'd0;
    legal = 1'b1;
    alt   = 1'b0;
    if (slot == 0) begin
      pick  = 0; // plain add on freshly reset registers.
      f3    = f3_add;
      r[3]  = 1'b0;
      valid = 1'b1;
    end

    if (pick < 45 || pick >= 95) begin
      alt = r[3] && (f3 == f3_add || f3 == f3_srl);
      if (pick >= 95) rd = 5'd0; // write to x0.
      word = {alt ? f7_alt : f7_base, rs2, rs1, f3, rd, opc_op};
    end else if (pick < 80) begin
      if (f3 == f3_sll) begin
        imm12[11:6] = 6'b000000;
      end else if (f3 == f3_srl) begin
        alt         = r[3];
        imm12[11:6] = alt ? 6'b010000 : 6'b000000;
      end
      word = {imm12, rs1, f3, rd, opc_op_imm};
    end else if (pick < 90) begin
      word = {r[31:12], rd, opc_lui};
    end else begin
      legal = 1'b0;
      case (r[17:16])
        2'd0:    word = {r[31:7], 7'b1100011}; // branch.
        2'd1:    word = {r[31:7], 7'b0000011}; // load.
        2'd2:    word = {f7_alt, rs2, rs1, r[0] ? f3_or : f3_xor, rd, opc_op};
        default: word = {7'b0000001, rs2, rs1, f3, rd, opc_op}; // m extension.
      endcase
    end

    a = (word[6:0] == opc_lui) ? '0 : shadow[word[19:15]];
    if (word[6:0] == opc_op) begin
      b = shadow[word[24:20]];
    end else if (word[6:0] == opc_lui) begin
      b = {{32{word[31]}}, word[31:12], 12'h000};
      f3 = f3_add;
    end else begin
      b = {{52{word[31]}}, word[31:20]};
    end
    res = model_result(f3, alt, a, b);

    instr_valid = valid;
    instr       = word;
    pc          = pc_next;
    pc_next     = pc_next + 64'd4;

    exp_retire  = valid && legal;
    exp_illegal = valid && !legal;
    exp_pc      = pc;
    exp_rd      = word[11:7];
    exp_data    = res;
    if (valid && legal && word[11:7] != 5'd0) begin
      shadow[word[11:7]] = res;
    end
  endtask

  task automatic check_retire();
    check_flag("retire_valid_o", retire_valid, exp_retire);
    check_flag("illegal_o", illegal, exp_illegal);
    if (exp_retire) begin
      check_data("retire_pc_o", retire_pc, exp_pc);
      check_rd("retire_rd_o", retire_rd, exp_rd);
      check_data("retire_data_o", retire_data, exp_data);
    end
  endtask

  always @(posedge clk) begin
    cycle_count = cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      fail_run("timeout: the instruction sequence did not finish in time");
    end
  end

  initial begin
    instr_valid = 1'b0;
    instr       = '0;
    pc          = '0;
    seed        = 32'h27ac_bc9b;
    cycle_count = 0;
    pc_next     = 64'h0000_0000_8000_0000;
    for (int i = 0; i < nregs; i++) begin
      shadow[i] = '0;
    end

    @(negedge clk);
    while (rst) @(negedge clk);
    check_flag("retire_valid_o", retire_valid, 1'b0); // idle after reset.
    check_flag("illegal_o", illegal, 1'b0);

    for (int slot = 0; slot < NUM_INSTR; slot++) begin
      issue_instr(slot);
      @(negedge clk);
      check_retire();
    end
    instr_valid = 1'b0;

    $display("Test completed successfully");
    $finish;
  end

endmodule

`default_nettype wire

// File: verilog/exu_pkg.sv
`default_nettype none

package exu_pkg;

  typedef logic [4:0] reg_idx_t;

  typedef enum logic [3:0] {
    alu_add,
    alu_sub,
    alu_sll,
    alu_slt,
    alu_sltu,
    alu_xor,
    alu_srl,
    alu_sra,
    alu_or,
    alu_and
  } alu_op_e;

  localparam int unsigned nregs = 32;

  // value after reset and on a disabled read port, cut to xlen by the user.
  localparam logic [63:0] reg_reset_val = 64'h0;

endpackage

`default_nettype wire

// File: verilog/exu_top.sv
`timescale 1ns/1ns
`default_nettype none

module exu_top #(
  parameter int XLEN = 64
) (
  input  logic               clk,
  input  logic               rst,
  input  logic               instr_valid_i,
  input  rv_isa_pkg::instr_t instr_i,
  input  logic [XLEN-1:0]    pc_i,

  output logic               retire_valid_o,
  output logic [XLEN-1:0]    retire_pc_o,
  output exu_pkg::reg_idx_t  retire_rd_o,
  output logic [XLEN-1:0]    retire_data_o,
  output logic               illegal_o
);

  import exu_pkg::*;

  reg_idx_t        rs1_idx;
  reg_idx_t        rs2_idx;
  reg_idx_t        rd_idx;
  logic            rs1_read_en;
  logic            rs2_read_en;
  logic            rd_wr_en;
  logic            use_imm;
  logic [63:0]     imm;
  alu_op_e         alu_op;
  logic            dec_illegal;
  logic [XLEN-1:0] rs1_data;
  logic [XLEN-1:0] rs2_data;
  logic [XLEN-1:0] op_b;
  logic [XLEN-1:0] alu_result;
  logic            wr_en;

  instr_decoder decoder_i (
    .instr_i       (instr_i),
    .rs1_idx_o     (rs1_idx),
    .rs2_idx_o     (rs2_idx),
    .rd_idx_o      (rd_idx),
    .rs1_read_en_o (rs1_read_en),
    .rs2_read_en_o (rs2_read_en),
    .rd_wr_en_o    (rd_wr_en),
    .use_imm_o     (use_imm),
    .imm_o         (imm),
    .alu_op_o      (alu_op),
    .illegal_o     (dec_illegal)
  );

  assign wr_en = instr_valid_i && rd_wr_en; // decoder clears rd_wr_en when illegal.

  int_regfile #(
    .XLEN (XLEN)
  ) regfile_i (
    .clk           (clk),
    .rst           (rst),
    .rd_wr_en_i    (wr_en),
    .rd_idx_i      (rd_idx),
    .rd_wr_data_i  (alu_result),
    .rs1_read_en_i (rs1_read_en),
    .rs2_read_en_i (rs2_read_en),
    .rs1_idx_i     (rs1_idx),
    .rs2_idx_i     (rs2_idx),
    .rs1_data_o    (rs1_data),
    .rs2_data_o    (rs2_data)
  );

  assign op_b = use_imm ? imm[XLEN-1:0] : rs2_data;

  int_alu #(
    .XLEN (XLEN)
  ) alu_i (
    .op_a_i   (rs1_data),
    .op_b_i   (op_b),
    .alu_op_i (alu_op),
    .result_o (alu_result)
  );

  // retire and illegal report one cycle after the edge that took the instruction.
  always_ff @(posedge clk) begin
    if (rst) begin
      retire_valid_o <= 1'b0;
      retire_pc_o    <= '0;
      retire_rd_o    <= '0;
      retire_data_o  <= '0;
      illegal_o      <= 1'b0;
    end else begin
      retire_valid_o <= instr_valid_i && !dec_illegal;
      illegal_o      <= instr_valid_i && dec_illegal;
      if (instr_valid_i) begin
        retire_pc_o   <= pc_i;
        retire_rd_o   <= rd_idx;
        retire_data_o <= alu_result; // kept even when rd is x0.
      end
    end
  end

endmodule

`default_nettype wire

// File: verilog/instr_decoder.sv
`timescale 1ns/1ns
`default_nettype none

module instr_decoder (
  input  rv_isa_pkg::instr_t instr_i,
  output exu_pkg::reg_idx_t  rs1_idx_o,
  output exu_pkg::reg_idx_t  rs2_idx_o,
  output exu_pkg::reg_idx_t  rd_idx_o,
  output logic               rs1_read_en_o,
  output logic               rs2_read_en_o,
  output logic               rd_wr_en_o,
  output logic               use_imm_o,
  output logic [63:0]        imm_o,
  output exu_pkg::alu_op_e   alu_op_o,
  output logic               illegal_o
);

  import rv_isa_pkg::*;
  import exu_pkg::*;

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  logic [5:0] funct6; // rv64 shift immediates keep shamt[5] in bit 25.
  logic       alt_ok; // f7_alt is allowed only on sub and sra.

  assign opcode = instr_i[6:0];
  assign funct3 = instr_i[f3_lsb +: 3];
  assign funct7 = instr_i[f7_lsb +: 7];
  assign funct6 = instr_i[f7_lsb+1 +: 6];

  assign rd_idx_o  = instr_i[rd_lsb +: 5];
  assign rs1_idx_o = instr_i[rs1_lsb +: 5];
  assign rs2_idx_o = instr_i[rs2_lsb +: 5];

  assign alt_ok = (funct3 == f3_add) || (funct3 == f3_srl);

  always_comb begin
    rs1_read_en_o = 1'b0;
    rs2_read_en_o = 1'b0;
    rd_wr_en_o    = 1'b0;
    use_imm_o     = 1'b0;
    imm_o         = '0;
    alu_op_o      = alu_add;
    illegal_o     = 1'b0;

    case (opcode)
      opc_op: begin
        rs1_read_en_o = 1'b1;
        rs2_read_en_o = 1'b1;
        rd_wr_en_o    = 1'b1;
        case (funct3)
          f3_add:  alu_op_o = (funct7 == f7_alt) ? alu_sub : alu_add;
          f3_sll:  alu_op_o = alu_sll;
          f3_slt:  alu_op_o = alu_slt;
          f3_sltu: alu_op_o = alu_sltu;
          f3_xor:  alu_op_o = alu_xor;
          f3_srl:  alu_op_o = (funct7 == f7_alt) ? alu_sra : alu_srl;
          f3_or:   alu_op_o = alu_or;
          f3_and:  alu_op_o = alu_and;
        endcase
        if (funct7 != f7_base && !(funct7 == f7_alt && alt_ok)) begin
          illegal_o = 1'b1;
        end
      end

      opc_op_imm: begin
        rs1_read_en_o = 1'b1;
        rd_wr_en_o    = 1'b1;
        use_imm_o     = 1'b1;
        imm_o         = {{52{instr_i[31]}}, instr_i[31:20]}; // i-immediate.
        case (funct3)
          f3_add:  alu_op_o = alu_add;
          f3_slt:  alu_op_o = alu_slt;
          f3_sltu: alu_op_o = alu_sltu;
          f3_xor:  alu_op_o = alu_xor;
          f3_or:   alu_op_o = alu_or;
          f3_and:  alu_op_o = alu_and;
          f3_sll: begin
            alu_op_o = alu_sll;
            if (funct6 != f7_base[6:1]) illegal_o = 1'b1;
          end
          f3_srl: begin
            alu_op_o = instr_i[sra_sel_bit] ? alu_sra : alu_srl;
            if (funct6 != f7_base[6:1] && funct6 != f7_alt[6:1]) illegal_o = 1'b1;
          end
        endcase
      end

      opc_lui: begin
        rd_wr_en_o = 1'b1; // rs1 stays unread, so operand a is zero.
        use_imm_o  = 1'b1;
        imm_o      = {{32{instr_i[31]}}, instr_i[31:12], 12'b0};
        alu_op_o   = alu_add;
      end

      default: illegal_o = 1'b1;
    endcase

    if (illegal_o) begin
      rs1_read_en_o = 1'b0;
      rs2_read_en_o = 1'b0;
      rd_wr_en_o    = 1'b0;
    end
  end

endmodule

`default_nettype wire

// File: verilog/int_alu.sv
`timescale 1ns/1ns
`default_nettype none

module int_alu #(
  parameter int XLEN = 64
) (
  input  logic [XLEN-1:0]  op_a_i,
  input  logic [XLEN-1:0]  op_b_i,
  input  exu_pkg::alu_op_e alu_op_i,
  output logic [XLEN-1:0]  result_o
);

  import exu_pkg::*;

  localparam int SHAMT_W = $clog2(XLEN); // 6 for rv64, 5 for rv32.

  logic [SHAMT_W-1:0] shamt;
  logic               lt_signed;
  logic               lt_unsigned;

  assign shamt       = op_b_i[SHAMT_W-1:0];
  assign lt_signed   = $signed(op_a_i) < $signed(op_b_i);
  assign lt_unsigned = op_a_i < op_b_i;

  always_comb begin
    case (alu_op_i)
      alu_add:  result_o = op_a_i + op_b_i;
      alu_sub:  result_o = op_a_i - op_b_i;
      alu_sll:  result_o = op_a_i << shamt;
      alu_slt:  result_o = {{(XLEN-1){1'b0}}, lt_signed};
      alu_sltu: result_o = {{(XLEN-1){1'b0}}, lt_unsigned};
      alu_xor:  result_o = op_a_i ^ op_b_i;
      alu_srl:  result_o = op_a_i >> shamt;
      alu_sra:  result_o = $unsigned($signed(op_a_i) >>> shamt); // sign fill.
      alu_or:   result_o = op_a_i | op_b_i;
      alu_and:  result_o = op_a_i & op_b_i;
      default:  result_o = '0;
    endcase
  end

endmodule

`default_nettype wire

// File: verilog/int_regfile.sv
`timescale 1ns/1ns
`default_nettype none

module int_regfile #(
  parameter int XLEN = 64
) (
  input  logic              clk,
  input  logic              rst,

  input  logic              rd_wr_en_i,
  input  exu_pkg::reg_idx_t rd_idx_i,
  input  logic [XLEN-1:0]   rd_wr_data_i,

  input  logic              rs1_read_en_i,
  input  logic              rs2_read_en_i,
  input  exu_pkg::reg_idx_t rs1_idx_i,
  input  exu_pkg::reg_idx_t rs2_idx_i,
  output logic [XLEN-1:0]   rs1_data_o,
  output logic [XLEN-1:0]   rs2_data_o
);

  import exu_pkg::*;

  logic [XLEN-1:0] regs [nregs];
  logic            regs_wr_en;

  // x0 never takes a write, so it keeps its reset value.
  assign regs_wr_en = rd_wr_en_i && (rd_idx_i != 5'd0);

  assign rs1_data_o = rs1_read_en_i ? regs[rs1_idx_i] : reg_reset_val[XLEN-1:0];
  assign rs2_data_o = rs2_read_en_i ? regs[rs2_idx_i] : reg_reset_val[XLEN-1:0];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < nregs; i++) begin
        regs[i] <= reg_reset_val[XLEN-1:0];
      end
    end else if (regs_wr_en) begin
      regs[rd_idx_i] <= rd_wr_data_i; // visible to the next read.
    end
  end

endmodule

`default_nettype wire

// File: verilog/rv_isa_pkg.sv
`default_nettype none

package rv_isa_pkg;

  typedef logic [31:0] instr_t;

  // major opcodes of the supported formats.
  localparam logic [6:0] opc_op     = 7'b0110011;
  localparam logic [6:0] opc_op_imm = 7'b0010011;
  localparam logic [6:0] opc_lui    = 7'b0110111;

  localparam logic [2:0] f3_add  = 3'b000; // also sub.
  localparam logic [2:0] f3_sll  = 3'b001;
  localparam logic [2:0] f3_slt  = 3'b010;
  localparam logic [2:0] f3_sltu = 3'b011;
  localparam logic [2:0] f3_xor  = 3'b100;
  localparam logic [2:0] f3_srl  = 3'b101; // also sra.
  localparam logic [2:0] f3_or   = 3'b110;
  localparam logic [2:0] f3_and  = 3'b111;

  localparam logic [6:0] f7_base = 7'b0000000;
  localparam logic [6:0] f7_alt  = 7'b0100000; // sub and sra.

  // low bit of each instruction field.
  localparam int rd_lsb  = 7;
  localparam int f3_lsb  = 12;
  localparam int rs1_lsb = 15;
  localparam int rs2_lsb = 20;
  localparam int f7_lsb  = 25;

  localparam int sra_sel_bit = 30; // arithmetic shift select in op-imm.

endpackage

`default_nettype wire

// File: vlog.f
verilog/rv_isa_pkg.sv
verilog/exu_pkg.sv
verilog/int_regfile.sv
verilog/instr_decoder.sv
verilog/int_alu.sv
verilog/exu_top.sv
test/clk_rst_gen.sv
test/exu_properties.sv
test/tb_exu.sv
